/* all.f */
+incdir+tests
logic/mshr_pkg.sv
logic/mshr_queue.sv
logic/mshr_match.sv
logic/mshr.sv
logic/miss_issue.sv
logic/fill_return.sv
logic/miss_unit.sv
tests/miss_unit_tb.sv

/* logic/fill_return.sv */
`timescale 1ns/100ps
`default_nettype none

module fill_return (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          fill_valid,
    input  logic                          empty,
    input  logic [mshr_pkg::slot_w-1:0]   head_rd,
    input  logic [mshr_pkg::slot_w-1:0]   head_sw,
    output logic                          dealloc,
    output logic                          wake_valid,
    output logic [mshr_pkg::slot_w-1:0]   wake_rd,
    output logic [mshr_pkg::slot_w-1:0]   wake_sw
);

    // stray fill with nothing outstanding is dropped.
    assign dealloc = fill_valid && !empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wake_valid <= 1'b0;
            wake_rd    <= '0;
            wake_sw    <= '0;
        end else begin
            wake_valid <= dealloc;
            wake_rd    <= dealloc ? head_rd : '0; // masks only with the strobe.
            wake_sw    <= dealloc ? head_sw : '0;
        end
    end

endmodule

`default_nettype wire

/* logic/miss_issue.sv */
`timescale 1ns/100ps
`default_nettype none

module miss_issue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic [mshr_pkg::addr_w-1:0]   req_addr,
    input  logic                          hit,
    input  logic                          full,
    output logic                          alloc,
    output logic                          mem_req_valid,
    output logic [mshr_pkg::line_w-1:0]   mem_req_line,
    output logic                          reject
);

    logic new_line;

    assign new_line = req_valid && !hit; // merges stay inside the mshr.
    assign alloc    = new_line && !full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
            reject        <= 1'b0;
        end else begin
            mem_req_valid <= alloc;
            reject        <= new_line && full;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            mem_req_line <= req_addr[mshr_pkg::addr_w-1:mshr_pkg::line_lsb];
        end
    end

endmodule

`default_nettype wire

/* logic/miss_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module miss_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic [mshr_pkg::addr_w-1:0]   req_addr,
    input  logic [mshr_pkg::slot_w-1:0]   req_slot,
    input  logic                          req_is_store,
    input  logic                          fill_valid,
    output logic                          mem_req_valid,
    output logic [mshr_pkg::line_w-1:0]   mem_req_line,
    output logic                          reject,
    output logic                          wake_valid,
    output logic [mshr_pkg::slot_w-1:0]   wake_rd,
    output logic [mshr_pkg::slot_w-1:0]   wake_sw,
    output logic                          mshr_full
);

    logic                        hit;
    logic                        alloc;
    logic                        dealloc;
    logic                        empty;
    logic [mshr_pkg::slot_w-1:0] head_rd;
    logic [mshr_pkg::slot_w-1:0] head_sw;

    miss_issue issue_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .hit           (hit),
        .full          (mshr_full),
        .alloc         (alloc),
        .mem_req_valid (mem_req_valid),
        .mem_req_line  (mem_req_line),
        .reject        (reject)
    );

    mshr mshr_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req_addr     (req_addr),
        .req_slot     (req_slot),
        .req_is_store (req_is_store),
        .alloc        (alloc),
        .dealloc      (dealloc),
        .hit          (hit),
        .full         (mshr_full),
        .empty        (empty),
        .head_rd      (head_rd),
        .head_sw      (head_sw)
    );

    fill_return fill_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_valid (fill_valid),
        .empty      (empty),
        .head_rd    (head_rd),
        .head_sw    (head_sw),
        .dealloc    (dealloc),
        .wake_valid (wake_valid),
        .wake_rd    (wake_rd),
        .wake_sw    (wake_sw)
    );

endmodule

`default_nettype wire

/* logic/mshr.sv */
`timescale 1ns/100ps
`default_nettype none

module mshr (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req_valid,
    input  logic [mshr_pkg::addr_w-1:0]   req_addr,
    input  logic [mshr_pkg::slot_w-1:0]   req_slot,
    input  logic                          req_is_store,
    input  logic                          alloc,
    input  logic                          dealloc,
    output logic                          hit,
    output logic                          full,
    output logic                          empty,
    output logic [mshr_pkg::slot_w-1:0]   head_rd,
    output logic [mshr_pkg::slot_w-1:0]   head_sw
);

    logic [mshr_pkg::line_w-1:0]                        req_line;
    logic [mshr_pkg::slot_w-1:0]                        req_rd;
    logic [mshr_pkg::slot_w-1:0]                        req_sw;
    logic [mshr_pkg::idx_w-1:0]                         pop_idx;
    logic [mshr_pkg::entries-1:0]                       pop_vec;
    logic [mshr_pkg::entries-1:0]                       hit_vec;
    logic [mshr_pkg::entries-1:0]                       upd_en;
    logic [mshr_pkg::entries-1:0]                       ent_valid;
    logic [mshr_pkg::entries-1:0][mshr_pkg::line_w-1:0] ent_line;
    logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] ent_rd;
    logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] ent_sw;
    logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] merged_rd;
    logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] merged_sw;

    assign req_line = req_addr[mshr_pkg::addr_w-1:mshr_pkg::line_lsb];
    assign req_rd   = req_is_store ? '0 : req_slot; // load slots.
    assign req_sw   = req_is_store ? req_slot : '0;

    // one-hot oldest entry while it is being freed.
    assign pop_vec = {{(mshr_pkg::entries - 1){1'b0}}, dealloc} << pop_idx;
    assign upd_en  = hit_vec & {mshr_pkg::entries{req_valid}};
    assign hit     = |hit_vec;

    // follows the queue head; dealloc only fires when not empty.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pop_idx <= '0;
        end else if (dealloc) begin
            pop_idx <= pop_idx + 1'b1;
        end
    end

    mshr_queue queue_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (alloc),
        .push_line (req_line),
        .push_rd   (req_rd),
        .push_sw   (req_sw),
        .pop       (dealloc),
        .upd_en    (upd_en),
        .upd_rd    (merged_rd),
        .upd_sw    (merged_sw),
        .ent_valid (ent_valid),
        .ent_line  (ent_line),
        .ent_rd    (ent_rd),
        .ent_sw    (ent_sw),
        .head_rd   (head_rd),
        .head_sw   (head_sw),
        .full      (full),
        .empty     (empty)
    );

    mshr_match match_inst (
        .req_line       (req_line),
        .req_rd         (req_rd),
        .req_sw         (req_sw),
        .head_idx_valid (pop_vec),
        .ent_valid      (ent_valid),
        .ent_line       (ent_line),
        .ent_rd         (ent_rd),
        .ent_sw         (ent_sw),
        .hit_vec        (hit_vec),
        .merged_rd      (merged_rd),
        .merged_sw      (merged_sw)
    );

endmodule

`default_nettype wire

/* logic/mshr_match.sv */
`timescale 1ns/100ps
`default_nettype none

module mshr_match (
    input  logic [mshr_pkg::line_w-1:0]                        req_line,
    input  logic [mshr_pkg::slot_w-1:0]                        req_rd,
    input  logic [mshr_pkg::slot_w-1:0]                        req_sw,
    input  logic [mshr_pkg::entries-1:0]                       head_idx_valid,
    input  logic [mshr_pkg::entries-1:0]                       ent_valid,
    input  logic [mshr_pkg::entries-1:0][mshr_pkg::line_w-1:0] ent_line,
    input  logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] ent_rd,
    input  logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] ent_sw,
    output logic [mshr_pkg::entries-1:0]                       hit_vec,
    output logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] merged_rd,
    output logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] merged_sw
);

    always_comb begin
        for (int i = 0; i < mshr_pkg::entries; i++) begin
            // an entry leaving this cycle can't take a merge.
            hit_vec[i] = ent_valid[i] && !head_idx_valid[i]
                         && (ent_line[i] == req_line);
            merged_rd[i] = ent_rd[i] | req_rd;
            merged_sw[i] = ent_sw[i] | req_sw;
        end
    end

endmodule

`default_nettype wire

/* logic/mshr_pkg.sv */
`default_nettype none

package mshr_pkg;

    // byte-granular physical address.
    localparam int addr_w = 15;

    // 16-byte lines.
    localparam int line_lsb = 4;
    localparam int line_w = addr_w - line_lsb;

    // miss status holding registers.
    localparam int entries = 8;
    localparam int idx_w = $clog2(entries);

    // one-hot mask over the load/store queue slots.
    localparam int slot_w = 8;

endpackage

`default_nettype wire

/* logic/mshr_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module mshr_queue (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             push,
    input  logic [mshr_pkg::line_w-1:0]                      push_line,
    input  logic [mshr_pkg::slot_w-1:0]                      push_rd,
    input  logic [mshr_pkg::slot_w-1:0]                      push_sw,
    input  logic                                             pop,
    input  logic [mshr_pkg::entries-1:0]                     upd_en,
    input  logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] upd_rd,
    input  logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] upd_sw,
    output logic [mshr_pkg::entries-1:0]                     ent_valid,
    output logic [mshr_pkg::entries-1:0][mshr_pkg::line_w-1:0] ent_line,
    output logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] ent_rd,
    output logic [mshr_pkg::entries-1:0][mshr_pkg::slot_w-1:0] ent_sw,
    output logic [mshr_pkg::slot_w-1:0]                      head_rd,
    output logic [mshr_pkg::slot_w-1:0]                      head_sw,
    output logic                                             full,
    output logic                                             empty
);

    logic [mshr_pkg::idx_w-1:0] head;
    logic [mshr_pkg::idx_w-1:0] tail;
    logic [mshr_pkg::idx_w:0]   count;
    logic                       do_push;
    logic                       do_pop;

    assign full  = count[mshr_pkg::idx_w]; // count tops out at entries.
    assign empty = (count == '0);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head_rd = ent_rd[head];
    assign head_sw = ent_sw[head];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            ent_valid <= '0;
        end else begin
            if (do_pop) begin
                ent_valid[head] <= 1'b0;
                head            <= head + 1'b1; // wraps at entries.
            end
            if (do_push) begin
                ent_valid[tail] <= 1'b1;
                tail            <= tail + 1'b1;
            end
            count <= count + (mshr_pkg::idx_w + 1)'(do_push)
                           - (mshr_pkg::idx_w + 1)'(do_pop);
        end
    end

    // line and masks.
    always_ff @(posedge clk) begin
        for (int i = 0; i < mshr_pkg::entries; i++) begin
            if (upd_en[i]) begin
                ent_rd[i] <= upd_rd[i];
                ent_sw[i] <= upd_sw[i];
            end
        end
        // tail is never a live entry, so no clash with an update.
        if (do_push) begin
            ent_line[tail] <= push_line;
            ent_rd[tail]   <= push_rd;
            ent_sw[tail]   <= push_sw;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# compile and run the miss_unit testbench with verilator.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --timescale 1ns/100ps -f all.f \
    --top-module miss_unit_tb -Mdir obj_dir -o miss_unit_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/miss_unit_sim > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$sim_log"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$sim_log"; then
    echo "simulation log has no final result"
    exit 1
fi
exit 0

/* tests/miss_unit_cases.svh */
`ifndef miss_unit_cases_svh
`define miss_unit_cases_svh

// each row gives op, addr, slot and store, then the mem_req_valid, mem_req_line, reject,
// wake_valid, wake_rd, wake_sw and mshr_full expected after the next edge.
task automatic build_table();
    begin_test("reset");
    add_row(op_idle, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_idle, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_idle, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_idle, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    begin_test("new_line");
    add_row(op_req,  15'h1234, 8'h01, 1'b0, 1'b1, 11'h123, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    begin_test("merge");
    add_row(op_req,  15'h1238, 8'h04, 1'b1, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h01, 8'h04, 1'b0);
    add_row(op_idle, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    begin_test("full");
    add_row(op_req,  15'h0100, 8'h01, 1'b0, 1'b1, 11'h010, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_req,  15'h0114, 8'h02, 1'b1, 1'b1, 11'h011, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_req,  15'h0128, 8'h04, 1'b0, 1'b1, 11'h012, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_req,  15'h013c, 8'h08, 1'b1, 1'b1, 11'h013, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_req,  15'h0140, 8'h10, 1'b0, 1'b1, 11'h014, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_req,  15'h0154, 8'h20, 1'b1, 1'b1, 11'h015, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_req,  15'h0168, 8'h40, 1'b0, 1'b1, 11'h016, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_req,  15'h017c, 8'h80, 1'b1, 1'b1, 11'h017, 1'b0, 1'b0, 8'h00, 8'h00, 1'b1);
    add_row(op_req,  15'h0900, 8'h80, 1'b0, 1'b0, 11'h000, 1'b1, 1'b0, 8'h00, 8'h00, 1'b1);
    add_row(op_req,  15'h012c, 8'h80, 1'b0, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b1);
    begin_test("fill_order");
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h01, 8'h00, 1'b0);
    add_row(op_req,  15'h0a08, 8'h40, 1'b1, 1'b1, 11'h0a0, 1'b0, 1'b0, 8'h00, 8'h00, 1'b1);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h00, 8'h02, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h84, 8'h00, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h00, 8'h08, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h10, 8'h00, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h00, 8'h20, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h40, 8'h00, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h00, 8'h80, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h00, 8'h40, 1'b0);
    begin_test("line_reuse");
    add_row(op_req,  15'h0164, 8'h02, 1'b0, 1'b1, 11'h016, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_idle, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b1, 8'h02, 8'h00, 1'b0);
    add_row(op_fill, 15'h0000, 8'h00, 1'b0, 1'b0, 11'h000, 1'b0, 1'b0, 8'h00, 8'h00, 1'b0);
endtask

`endif

/* tests/miss_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module miss_unit_tb;

    localparam logic [1:0] op_idle = 2'd0;
    localparam logic [1:0] op_req  = 2'd1;
    localparam logic [1:0] op_fill = 2'd2;
    localparam int max_rows     = 64;
    localparam int reset_cycles = 16;

    logic                        clk;
    logic                        rst_n;
    logic                        req_valid;
    logic [mshr_pkg::addr_w-1:0] req_addr;
    logic [mshr_pkg::slot_w-1:0] req_slot;
    logic                        req_is_store;
    logic                        fill_valid;
    logic                        mem_req_valid;
    logic [mshr_pkg::line_w-1:0] mem_req_line;
    logic                        reject;
    logic                        wake_valid;
    logic [mshr_pkg::slot_w-1:0] wake_rd;
    logic [mshr_pkg::slot_w-1:0] wake_sw;
    logic                        mshr_full;

    string                       tab_name  [max_rows];
    logic [1:0]                  tab_op    [max_rows];
    logic [mshr_pkg::addr_w-1:0] tab_addr  [max_rows];
    logic [mshr_pkg::slot_w-1:0] tab_slot  [max_rows];
    logic                        tab_store [max_rows];
    logic                        tab_mrv   [max_rows];
    logic [mshr_pkg::line_w-1:0] tab_line  [max_rows];
    logic                        tab_rej   [max_rows];
    logic                        tab_wv    [max_rows];
    logic [mshr_pkg::slot_w-1:0] tab_rd    [max_rows];
    logic [mshr_pkg::slot_w-1:0] tab_sw    [max_rows];
    logic                        tab_full  [max_rows];

    int    n_rows = 0;
    string cur_test = "";
    logic  table_ready = 1'b0;
    int    errors = 0;
    int    test_errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    cycles = 0;
    int    cycle_limit = 0;

    miss_unit miss_unit_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_addr      (req_addr),
        .req_slot      (req_slot),
        .req_is_store  (req_is_store),
        .fill_valid    (fill_valid),
        .mem_req_valid (mem_req_valid),
        .mem_req_line  (mem_req_line),
        .reject        (reject),
        .wake_valid    (wake_valid),
        .wake_rd       (wake_rd),
        .wake_sw       (wake_sw),
        .mshr_full     (mshr_full)
    );

    task automatic begin_test(input string name);
        cur_test = name;
    endtask

    task automatic add_row(input logic [1:0] op, input logic [mshr_pkg::addr_w-1:0] addr,
                           input logic [mshr_pkg::slot_w-1:0] slot, input logic store,
                           input logic mrv, input logic [mshr_pkg::line_w-1:0] line,
                           input logic rej, input logic wv,
                           input logic [mshr_pkg::slot_w-1:0] rd,
                           input logic [mshr_pkg::slot_w-1:0] sw, input logic full);
        tab_name[n_rows]  = cur_test;
        tab_op[n_rows]    = op;
        tab_addr[n_rows]  = addr;
        tab_slot[n_rows]  = slot;
        tab_store[n_rows] = store;
        tab_mrv[n_rows]   = mrv;
        tab_line[n_rows]  = line;
        tab_rej[n_rows]   = rej;
        tab_wv[n_rows]    = wv;
        tab_rd[n_rows]    = rd;
        tab_sw[n_rows]    = sw;
        tab_full[n_rows]  = full;
        n_rows++;
    endtask

    `include "miss_unit_cases.svh"

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", name, field, expected, actual);
        errors++;
        test_errors++;
    endtask

    task automatic drive_row(input int idx);
        req_valid    = (tab_op[idx] == op_req);
        req_addr     = tab_addr[idx];
        req_slot     = tab_slot[idx];
        req_is_store = tab_store[idx];
        fill_valid   = (tab_op[idx] == op_fill);
    endtask

    task automatic check_row(input int idx);
        if (mem_req_valid !== tab_mrv[idx]) begin
            report_mismatch(tab_name[idx], "mem_req_valid", 32'(tab_mrv[idx]),
                            32'(mem_req_valid));
        end
        if (tab_mrv[idx] && mem_req_line !== tab_line[idx]) begin // line only with the strobe.
            report_mismatch(tab_name[idx], "mem_req_line", 32'(tab_line[idx]),
                            32'(mem_req_line));
        end
        if (reject !== tab_rej[idx]) begin
            report_mismatch(tab_name[idx], "reject", 32'(tab_rej[idx]), 32'(reject));
        end
        if (wake_valid !== tab_wv[idx]) begin
            report_mismatch(tab_name[idx], "wake_valid", 32'(tab_wv[idx]), 32'(wake_valid));
        end
        if (wake_rd !== tab_rd[idx]) begin
            report_mismatch(tab_name[idx], "wake_rd", 32'(tab_rd[idx]), 32'(wake_rd));
        end
        if (wake_sw !== tab_sw[idx]) begin
            report_mismatch(tab_name[idx], "wake_sw", 32'(tab_sw[idx]), 32'(wake_sw));
        end
        if (mshr_full !== tab_full[idx]) begin
            report_mismatch(tab_name[idx], "mshr_full", 32'(tab_full[idx]), 32'(mshr_full));
        end
    endtask

    task automatic close_test(input int idx);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", tab_name[idx]);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", tab_name[idx], test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req_addr     = '0;
        req_slot     = '0;
        req_is_store = 1'b0;
        fill_valid   = 1'b0;
        build_table();
        cycle_limit = reset_cycles + 2 * n_rows + 10;
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            drive_row(i);
            @(posedge clk);
            #1; // outputs of edge settled.
            check_row(i);
            if (i == n_rows - 1 || tab_name[i + 1] != tab_name[i]) begin
                close_test(i);
            end
        end
        req_valid  = 1'b0;
        fill_valid = 1'b0;
        $display("tests: %0d run, %0d failed; rows: %0d, mismatches: %0d",
                 tests_run, tests_failed, n_rows, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog over the whole run.
    initial begin
        wait (table_ready);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not end within %0d clock cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
